// File: led_game_top.f
+incdir+common
common/matrix_pkg.sv
common/max7219_pkg.sv
common/column_if.sv
logic/button_debounce.sv
game/screen_loader.sv
game/frame_buffer.sv
max7219/max7219_driver.sv
logic/led_game_top.sv
dv/led_game_properties.sv
dv/led_game_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the LED matrix testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f led_game_top.f \
	--top-module led_game_tb -Mdir obj_dir -o led_game_sim \
	&& ./obj_dir/led_game_sim | tee /dev/stderr | grep -q "Test OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: dv/led_game_tb.sv
// Testbench for the LED matrix display path
// Drives the buttons, decodes the MAX7219 serial words and checks them
// against its own picture table
`timescale 1ns/1ps
`include "matrix_defines.svh"
`default_nettype none

module led_game_tb
	import matrix_pkg::*, max7219_pkg::*;
();
	localparam int BTN_START = 0;
	localparam int BTN_LEFT = 1;
	localparam int BTN_RIGHT = 2;
	localparam int RX_DEPTH = 512;
	// Gap, fetch and 16 serial bits plus margin
	localparam int WORD_CYCLES = 80;
	localparam int MAX_PRESSES = 11;
	// Init, first frame, three frames per press, glitch test and last frame
	localparam int TIMEOUT_CYCLES =
		WORD_CYCLES * (5 + 8 * (1 + 3 * MAX_PRESSES + 3 + 1)) + 1000;

	logic clock_50 = 1'b0;
	logic rst_n;
	logic start_button;
	logic left_button;
	logic right_button;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;

	logic        prev_clk;
	logic        prev_ncs;
	logic [15:0] shift_reg;
	int          bit_count;
	logic [15:0] rx_word_mem [RX_DEPTH];
	int          rx_len_mem [RX_DEPTH];
	int          rx_wr_count;
	int          rx_rd_count;

	screen_idx_t exp_screen;
	int          check_from;
	int          frame_idx;
	int          checked_frames;
	int          word_num;
	digit_addr_t next_digit = 4'd1;
	int          errors;
	int          framing_errors;
	int          tests_run;
	int          tests_failed;
	int          cycle_count;
	int unsigned rand_state = 70;

	led_game_top i_led_game_top (
		.clock_50     (clock_50),
		.rst_n        (rst_n),
		.start_button (start_button),
		.left_button  (left_button),
		.right_button (right_button),
		.max7219_din  (max7219_din),
		.max7219_ncs  (max7219_ncs),
		.max7219_clk  (max7219_clk)
	);

	always #20 clock_50 = ~clock_50;

	always @(posedge clock_50) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the display words stopped arriving within %0d cycles", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	//==========================================================================
	// Reference model
	//==========================================================================
	function automatic int unsigned lcg_next(input int unsigned limit);
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return (rand_state >> 16) % limit;
	endfunction

	// Row 0 in the top byte and bit 7 leftmost
	function automatic logic [63:0] picture_rows(input screen_idx_t screen);
		case (screen)
			SCR_START:  return 64'h0066_4444_2222_6600;
			SCR_GO:     return 64'h0066_8989_B999_6600;
			SCR_L1:     return 64'h0008_1808_0808_1C00;
			SCR_L2:     return 64'h0018_2404_0810_3C00;
			SCR_L3:     return 64'h0018_2404_0804_2418;
			default:    return 64'h0024_2400_4224_3C00;
		endcase
	endfunction

	function automatic col_bits_t expected_column(input screen_idx_t screen,
			input digit_addr_t digit);
		logic [63:0] pic;
		row_bits_t   row;
		col_bits_t   col;
		int          c;
		pic = picture_rows(screen);
		c = int'(digit) - 1;
		col = '0;
		for (int r = 0; r < 8; r++) begin
			row = pic[(7 - r) * 8 +: 8];
			col[7 - r] = row[7 - c];
		end
		return col;
	endfunction

	function automatic logic [15:0] expected_init_word(input int idx);
		case (idx)
			0:       return 16'h0C01;
			1:       return 16'h0900;
			2:       return 16'h0B07;
			3:       return {8'h0A, `MATRIX_INTENSITY};
			default: return 16'h0F00;
		endcase
	endfunction

	//==========================================================================
	// Serial capture and compare
	//==========================================================================
	always @(posedge clock_50) begin
		if (!rst_n) begin
			prev_clk = 1'b0;
			prev_ncs = 1'b1;
			bit_count = 0;
			shift_reg = '0;
		end else begin
			if (prev_ncs && !max7219_ncs) begin
				bit_count = 0;
			end
			if (!prev_clk && max7219_clk && !max7219_ncs) begin
				shift_reg = {shift_reg[14:0], max7219_din};
				bit_count++;
			end
			// Rising ncs closes a word
			if (!prev_ncs && max7219_ncs) begin
				rx_word_mem[rx_wr_count % RX_DEPTH] = shift_reg;
				rx_len_mem[rx_wr_count % RX_DEPTH] = bit_count;
				rx_wr_count++;
			end
			prev_clk = max7219_clk;
			prev_ncs = max7219_ncs;
		end
	end

	task automatic check_word(input logic [15:0] raw, input int nbits);
		max7219_word_u w;
		col_bits_t     exp_col;
		w = raw;
		assert (nbits == 16) else begin
			errors++;
			framing_errors++;
			$display("Fail at %0t ns: word %0d has %0d bits, expected 16", $time, word_num, nbits);
		end
		if (word_num < 5) begin
			assert (raw == expected_init_word(word_num)) else begin
				errors++;
				$display("Fail at %0t ns: init word %0d is register %h value %h, expected %h",
					$time, word_num, w.ctrl.addr, w.ctrl.value, expected_init_word(word_num));
			end
		end else begin
			assert (w.digit.addr == next_digit) else begin
				errors++;
				framing_errors++;
				$display("Fail at %0t ns: digit %0d received where digit %0d was due",
					$time, w.digit.addr, next_digit);
			end
			if (w.digit.addr == 4'd1) begin
				frame_idx++;
			end
			if (frame_idx >= check_from && w.digit.addr >= 4'd1 && w.digit.addr <= 4'd8) begin
				exp_col = expected_column(exp_screen, w.digit.addr);
				assert (w.digit.cols == exp_col) else begin
					errors++;
					$display("Fail at %0t ns: screen %0d digit %0d column %h, expected %h",
						$time, exp_screen, w.digit.addr, w.digit.cols, exp_col);
				end
				if (w.digit.addr == 4'd8) begin
					checked_frames++;
				end
			end
			next_digit = (w.digit.addr == 4'd8) ? 4'd1 : w.digit.addr + 4'd1;
		end
		word_num++;
	endtask

	always @(negedge clock_50) begin
		if (rx_rd_count != rx_wr_count) begin
			check_word(rx_word_mem[rx_rd_count % RX_DEPTH], rx_len_mem[rx_rd_count % RX_DEPTH]);
			rx_rd_count++;
		end
	end

	//==========================================================================
	// Stimulus
	//==========================================================================
	task automatic drive_button(input int button, input logic level);
		case (button)
			BTN_START: start_button = level;
			BTN_LEFT:  left_button = level;
			default:   right_button = level;
		endcase
	endtask

	// Second full frame after the press shows the new screen
	task automatic apply_press(input int button);
		@(posedge clock_50);
		#2;
		check_from = frame_idx + 2;
		case (button)
			BTN_START: exp_screen = SCR_START;
			BTN_RIGHT: exp_screen = screen_idx_t'((int'(exp_screen) + 1) % `SCREEN_COUNT);
			default:   exp_screen = screen_idx_t'((int'(exp_screen) + `SCREEN_COUNT - 1)
				% `SCREEN_COUNT);
		endcase
		drive_button(button, 1'b0);
		repeat (`DEBOUNCE_CYCLES + 4) @(posedge clock_50);
		#2;
		drive_button(button, 1'b1);
		repeat (4) @(posedge clock_50);
	endtask

	task automatic glitch_button(input int button, input int len);
		@(posedge clock_50);
		#2;
		drive_button(button, 1'b0);
		repeat (len) @(posedge clock_50);
		#2;
		drive_button(button, 1'b1);
		repeat (6) @(posedge clock_50);
	endtask

	task automatic wait_checked_frames(input int count);
		int target;
		target = checked_frames + count;
		while (checked_frames < target) begin
			@(posedge clock_50);
		end
	endtask

	task automatic report_test(input int num, input string name, input bit ok);
		tests_run++;
		if (!ok) begin
			tests_failed++;
		end
		$display("test %0d %s: %s", num, name, ok ? "pass" : "fail");
	endtask

	initial begin
		int n_right;
		int err_mark;
		int button;
		int len;
		rst_n = 1'b0;
		start_button = 1'b1;
		left_button = 1'b1;
		right_button = 1'b1;
		exp_screen = SCR_START;
		check_from = 1;
		repeat (4) @(posedge clock_50);
		#2;
		rst_n = 1'b1;

		err_mark = errors;
		wait_checked_frames(1);
		report_test(1, "init words and start screen", errors == err_mark);

		err_mark = errors;
		n_right = 2 + int'(lcg_next(2));
		for (int i = 0; i < n_right; i++) begin
			apply_press(BTN_RIGHT);
			wait_checked_frames(1);
		end
		report_test(2, "right steps", errors == err_mark);

		// One more than the right steps so the index wraps to the winner screen
		err_mark = errors;
		for (int i = 0; i < n_right + 1; i++) begin
			apply_press(BTN_LEFT);
			wait_checked_frames(1);
		end
		report_test(3, "left steps with wrap", errors == err_mark);

		err_mark = errors;
		apply_press(BTN_START);
		wait_checked_frames(1);
		apply_press(BTN_RIGHT);
		wait_checked_frames(1);
		apply_press(BTN_START);
		wait_checked_frames(1);
		report_test(4, "start returns to start screen", errors == err_mark);

		// Off the start screen, so a start glitch would also show
		err_mark = errors;
		apply_press(BTN_RIGHT);
		wait_checked_frames(1);
		for (int i = 0; i < 4; i++) begin
			button = int'(lcg_next(3));
			len = 1 + int'(lcg_next(`DEBOUNCE_CYCLES - 1));
			glitch_button(button, len);
		end
		wait_checked_frames(2);
		report_test(5, "short glitches ignored", errors == err_mark);

		wait_checked_frames(1);
		report_test(6, "word length and digit order", framing_errors == 0);

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/led_game_properties.sv
// Protocol checks for the MAX7219 driver
// Serial clock idle level and the four-phase column handshake
`timescale 1ns/1ps
`default_nettype none

module led_game_properties (
	input logic clock_50,
	input logic rst_n,
	input logic req,
	input logic ack,
	input logic max7219_ncs,
	input logic max7219_clk
);

	// Serial clock stays low outside a word
	a_clk_idle : assert property (@(posedge clock_50) disable iff (!rst_n)
		max7219_ncs |-> !max7219_clk)
		else $error("serial clock is high while ncs is high");

	a_ack_after_req : assert property (@(posedge clock_50) disable iff (!rst_n)
		$rose(ack) |-> req)
		else $error("ack rose without a pending req");

	// Req holds until the buffer has answered
	a_req_held : assert property (@(posedge clock_50) disable iff (!rst_n)
		(req && !ack) |=> req)
		else $error("req dropped before ack arrived");

endmodule

bind max7219_driver led_game_properties i_led_game_properties (
	.clock_50    (clock_50),
	.rst_n       (rst_n),
	.req         (col.req),
	.ack         (col.ack),
	.max7219_ncs (max7219_ncs),
	.max7219_clk (max7219_clk)
);

`default_nettype wire

// File: logic/led_game_top.sv
// LED matrix display top level
// Debounced buttons select one of six pictures shown on a MAX7219 8x8 matrix
`timescale 1ns/1ps
`default_nettype none

module led_game_top
	import matrix_pkg::*;
(
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_button,
	input  logic left_button,
	input  logic right_button,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);
	logic      start_press;
	logic      left_press;
	logic      right_press;
	logic      row_we;
	row_idx_t  row_sel;
	row_bits_t row_data;

	column_if col_bus ();

	//==========================================================================
	// Buttons
	//==========================================================================
	button_debounce i_start_debounce (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button   (start_button),
		.press    (start_press)
	);

	button_debounce i_left_debounce (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button   (left_button),
		.press    (left_press)
	);

	button_debounce i_right_debounce (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.button   (right_button),
		.press    (right_press)
	);

	//==========================================================================
	// Picture path to the display
	//==========================================================================
	screen_loader i_screen_loader (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start_press (start_press),
		.left_press  (left_press),
		.right_press (right_press),
		.row_we      (row_we),
		.row_sel     (row_sel),
		.row_data    (row_data)
	);

	frame_buffer i_frame_buffer (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.row_we   (row_we),
		.row_sel  (row_sel),
		.row_data (row_data),
		.col      (col_bus.producer)
	);

	max7219_driver i_max7219_driver (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.col         (col_bus.consumer),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

// File: max7219/max7219_driver.sv
// MAX7219 serial driver
// Sends the init words once, then refreshes digits 1 to 8 forever,
// fetching each column from the frame buffer over the req/ack link
`timescale 1ns/1ps
`include "matrix_defines.svh"
`default_nettype none

module max7219_driver
	import matrix_pkg::*, max7219_pkg::*;
(
	input  logic       clock_50,
	input  logic       rst_n,
	column_if.consumer col,
	output logic       max7219_din,
	output logic       max7219_ncs,
	output logic       max7219_clk
);
	localparam int GAP_CYCLES = 2 * `SCLK_DIV;
	localparam int CNT_W = $clog2(GAP_CYCLES + 1);
	localparam logic [2:0] INIT_WORDS = 3'd5;

	typedef enum logic [1:0] {ST_GAP, ST_FETCH, ST_SHIFT} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [3:0]       bit_cnt;
	logic [2:0]       init_idx;
	digit_addr_t      digit;
	max7219_word_u    word_q;
	max7219_word_u    load_word;
	logic             init_done;
	logic             gap_done;
	logic             load;

	// Power-up sequence
	function automatic max7219_word_u init_word(input logic [2:0] idx);
		max7219_word_u w;
		case (idx)
			3'd0:    w.ctrl = '{4'h0, REG_SHUTDOWN, 8'h01};
			3'd1:    w.ctrl = '{4'h0, REG_DECODE_MODE, 8'h00};
			3'd2:    w.ctrl = '{4'h0, REG_SCAN_LIMIT, 8'h07};
			3'd3:    w.ctrl = '{4'h0, REG_INTENSITY, `MATRIX_INTENSITY};
			default: w.ctrl = '{4'h0, REG_DISPLAY_TEST, 8'h00};
		endcase
		return w;
	endfunction

	assign init_done = (init_idx == INIT_WORDS);
	assign gap_done  = (state == ST_GAP) && (cnt == CNT_W'(GAP_CYCLES - 1));
	assign load      = (gap_done && !init_done) || (state == ST_FETCH && col.ack);
	assign col.addr  = digit;

	always_comb begin
		if (init_done) begin
			load_word.digit = '{4'h0, digit, col.data};
		end else begin
			load_word = init_word(init_idx);
		end
	end

	always_ff @(posedge clock_50) begin
		if (load) begin
			word_q <= load_word;
		end
	end

	//==========================================================================
	// Word sequencing and bit shifting
	//==========================================================================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state       <= ST_GAP;
			cnt         <= '0;
			bit_cnt     <= '0;
			init_idx    <= '0;
			digit       <= REG_DIGIT_FIRST;
			col.req     <= 1'b0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			max7219_din <= 1'b0;
		end else if (load) begin
			// Open the frame with the MSB on din
			state       <= ST_SHIFT;
			cnt         <= '0;
			bit_cnt     <= 4'd15;
			col.req     <= 1'b0;
			max7219_ncs <= 1'b0;
			max7219_din <= load_word[15];
			if (init_done) begin
				digit <= (digit == REG_DIGIT_LAST) ? REG_DIGIT_FIRST : digit + 4'd1;
			end else begin
				init_idx <= init_idx + 1'b1;
			end
		end else begin
			case (state)
				ST_GAP: begin
					if (!gap_done) begin
						cnt <= cnt + 1'b1;
					end else if (!col.ack) begin
						col.req <= 1'b1;
						state   <= ST_FETCH;
					end
				end
				ST_SHIFT: begin
					if (cnt != CNT_W'(`SCLK_DIV - 1)) begin
						cnt <= cnt + 1'b1;
					end else begin
						cnt <= '0;
						if (!max7219_clk) begin
							max7219_clk <= 1'b1;
						end else begin
							max7219_clk <= 1'b0;
							if (bit_cnt == 4'd0) begin
								max7219_ncs <= 1'b1;
								max7219_din <= 1'b0;
								state       <= ST_GAP;
							end else begin
								bit_cnt     <= bit_cnt - 4'd1;
								max7219_din <= word_q[bit_cnt - 4'd1];
							end
						end
					end
				end
				// Waiting for ack in ST_FETCH
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: game/frame_buffer.sv
// Frame buffer
// Eight row registers written by the loader, read back one column at a time
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
	import matrix_pkg::*;
(
	input  logic        clock_50,
	input  logic        rst_n,
	input  logic        row_we,
	input  row_idx_t    row_sel,
	input  row_bits_t   row_data,
	column_if.producer  col
);
	row_bits_t  rows [8];
	logic [2:0] col_idx;
	col_bits_t  col_word;

	// Digit 1 shows the leftmost column
	assign col_idx = 3'(col.addr - 4'd1);

	// Transpose, row r lands on bit 7-r
	always_comb begin
		col_word = '0;
		for (int r = 0; r < 8; r++) begin
			col_word[7 - r] = rows[r][7 - col_idx];
		end
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			for (int r = 0; r < 8; r++) begin
				rows[r] <= '0;
			end
		end else if (row_we) begin
			rows[row_sel] <= row_data;
		end
	end

	// Four-phase handshake
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			col.ack <= 1'b0;
		end else if (col.req && !col.ack) begin
			col.ack  <= 1'b1;
			col.data <= col_word;
		end else if (!col.req && col.ack) begin
			col.ack <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: game/screen_loader.sv
// Screen loader
// Keeps the current screen, steps it on button presses and writes
// the chosen picture into the frame buffer one row per cycle
`timescale 1ns/1ps
`include "matrix_defines.svh"
`default_nettype none

module screen_loader
	import matrix_pkg::*;
(
	input  logic        clock_50,
	input  logic        rst_n,
	input  logic        start_press,
	input  logic        left_press,
	input  logic        right_press,
	output logic        row_we,
	output row_idx_t    row_sel,
	output row_bits_t   row_data
);
	localparam screen_idx_t LAST_SCREEN = screen_idx_t'(`SCREEN_COUNT - 1);

	//==========================================================================
	// Pictures, row 0 in the top byte
	//==========================================================================
	localparam logic [63:0] PIC_START  = 64'h0066_4444_2222_6600;
	localparam logic [63:0] PIC_GO     = 64'h0066_8989_B999_6600;
	localparam logic [63:0] PIC_L1     = 64'h0008_1808_0808_1C00;
	localparam logic [63:0] PIC_L2     = 64'h0018_2404_0810_3C00;
	localparam logic [63:0] PIC_L3     = 64'h0018_2404_0804_2418;
	localparam logic [63:0] PIC_WINNER = 64'h0024_2400_4224_3C00;

	screen_idx_t screen;
	logic        busy;
	row_idx_t    row_cnt;
	logic [63:0] picture;

	always_comb begin
		case (screen)
			SCR_START:  picture = PIC_START;
			SCR_GO:     picture = PIC_GO;
			SCR_L1:     picture = PIC_L1;
			SCR_L2:     picture = PIC_L2;
			SCR_L3:     picture = PIC_L3;
			SCR_WINNER: picture = PIC_WINNER;
			default:    picture = PIC_START;
		endcase
	end

	assign row_we   = busy;
	assign row_sel  = row_cnt;
	assign row_data = picture[(7 - row_cnt) * 8 +: 8];

	//==========================================================================
	// Screen stepping and row write sequence
	//==========================================================================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			screen  <= SCR_START;
			busy    <= 1'b1;
			row_cnt <= '0;
		end else if (busy) begin
			// Counter wraps to row 0 for the next picture
			row_cnt <= row_cnt + 1'b1;
			if (row_cnt == 3'd7) begin
				busy <= 1'b0;
			end
		end else if (start_press || right_press || left_press) begin
			busy <= 1'b1;
			if (start_press) begin
				screen <= SCR_START;
			end else if (right_press) begin
				screen <= (screen == LAST_SCREEN) ? SCR_START : screen + 1'b1;
			end else begin
				screen <= (screen == SCR_START) ? LAST_SCREEN : screen - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/button_debounce.sv
// Button debouncer
// Synchronizes one active-low button and pulses press once per stable push
`timescale 1ns/1ps
`include "matrix_defines.svh"
`default_nettype none

module button_debounce (
	input  logic clock_50,
	input  logic rst_n,
	input  logic button,
	output logic press
);
	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`DEBOUNCE_CYCLES);

	logic             sync_1;
	logic             sync_2;
	logic [CNT_W-1:0] low_cnt;

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			sync_1  <= 1'b1;
			sync_2  <= 1'b1;
			low_cnt <= '0;
			press   <= 1'b0;
		end else begin
			sync_1 <= button;
			sync_2 <= sync_1;
			press  <= 1'b0;
			// Released, so rearm
			if (sync_2) begin
				low_cnt <= '0;
			end else if (low_cnt != CNT_MAX) begin
				low_cnt <= low_cnt + 1'b1;
				press   <= (low_cnt == CNT_MAX - 1'b1);
			end
		end
	end

endmodule

`default_nettype wire

// File: common/column_if.sv
// Column fetch link between frame buffer and MAX7219 driver
// Four-phase req/ack, the driver asks for a digit and the buffer returns its column
`timescale 1ns/1ps
`default_nettype none

interface column_if
	import matrix_pkg::*;
();
	logic        req;
	digit_addr_t addr;
	logic        ack;
	col_bits_t   data;

	modport producer (input req, input addr, output ack, output data);
	modport consumer (output req, output addr, input ack, input data);
endinterface

`default_nettype wire

// File: common/max7219_pkg.sv
// MAX7219 register map and serial word layout
// A 16-bit word carries either a digit column or a control register value
`default_nettype none

package max7219_pkg;
	import matrix_pkg::*;

	typedef enum logic [3:0] {
		REG_DIGIT_FIRST  = 4'h1,
		REG_DIGIT_LAST   = 4'h8,
		REG_DECODE_MODE  = 4'h9,
		REG_INTENSITY    = 4'hA,
		REG_SCAN_LIMIT   = 4'hB,
		REG_SHUTDOWN     = 4'hC,
		REG_DISPLAY_TEST = 4'hF
	} max7219_reg_e;

	typedef struct packed {
		logic [3:0]  pad;
		digit_addr_t addr;
		col_bits_t   cols;
	} digit_word_t;

	typedef struct packed {
		logic [3:0]   pad;
		max7219_reg_e addr;
		logic [7:0]   value;
	} ctrl_word_t;

	// Same 16 bits, read as digit data or as a control write
	typedef union packed {
		digit_word_t digit;
		ctrl_word_t  ctrl;
	} max7219_word_u;

endpackage

`default_nettype wire

// File: common/matrix_pkg.sv
// Matrix display types
// Row and column bytes, digit addresses and screen numbers for the 8x8 path
`default_nettype none

package matrix_pkg;

	// One picture row, bit 7 is the leftmost LED
	typedef logic [7:0] row_bits_t;

	// One display column, bit 7 is row 0
	typedef logic [7:0] col_bits_t;

	typedef logic [2:0] row_idx_t;

	// MAX7219 digit register, 1 to 8
	typedef logic [3:0] digit_addr_t;

	typedef logic [2:0] screen_idx_t;

	// Screen order as seen when stepping right
	localparam screen_idx_t SCR_START  = 3'd0;
	localparam screen_idx_t SCR_GO     = 3'd1;
	localparam screen_idx_t SCR_L1     = 3'd2;
	localparam screen_idx_t SCR_L2     = 3'd3;
	localparam screen_idx_t SCR_L3     = 3'd4;
	localparam screen_idx_t SCR_WINNER = 3'd5;

endpackage

`default_nettype wire

// File: common/matrix_defines.svh
// Matrix display build constants
// Debounce length, serial clock rate, brightness and screen count
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

// Stable low cycles before a press counts
`define DEBOUNCE_CYCLES 8

// System clocks per half period of the serial clock
`define SCLK_DIV 2

// Brightness, 0x0 to 0xF
`define MATRIX_INTENSITY 8'h0A

`define SCREEN_COUNT 6

`endif
